/* logic/axil_pkg.sv */
// Shared widths, response codes, FSM states and channel structs, imported by every RTL module.
package axil_pkg;

    // ----------------------------------------------------------------------
    // Widths and target depth.
    // ----------------------------------------------------------------------
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;
    // Power of two, so the range check is a test of the upper address bits.
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // ----------------------------------------------------------------------
    // Encodings.
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    // ----------------------------------------------------------------------
    // Channel payloads; valid and ready travel beside them.
    // ----------------------------------------------------------------------
    typedef struct packed {logic [ADDR_W-1:0] addr;} axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {axil_resp_e resp;} axil_b_t;
    typedef struct packed {logic [ADDR_W-1:0] addr;} axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axil_resp_e        resp;
    } axil_r_t;

    // Engine completion. Done pulses, fault and data hold until the next one.
    typedef struct packed {
        logic              done;
        logic              fault;
        logic [DATA_W-1:0] data;
    } eng_result_t;

endpackage

/* logic/axil_master_write.sv */
// AXI4-Lite write engine; one start strobe issues a single write and reports its response.
`timescale 1ns/1ps

module axil_master_write
    import axil_pkg::*;
(
    // Clock and reset.
    input  logic              clk,
    input  logic              i_arst_n,

    // User request.
    input  logic              i_start,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic [STRB_W-1:0] i_strb,

    // Write address channel.
    input  logic              i_aw_ready,
    output logic              o_aw_valid,
    output axil_aw_t          o_aw,

    // Write data channel.
    input  logic              i_w_ready,
    output logic              o_w_valid,
    output axil_w_t           o_w,

    // Write response channel.
    input  logic              i_b_valid,
    input  axil_b_t           i_b,
    output logic              o_b_ready,

    // Status.
    output logic              o_busy,
    output eng_result_t       o_result
);
    wr_state_e state;
    logic      aw_pend;
    logic      w_pend;
    logic      aw_hs;
    logic      w_hs;
    logic      b_hs;

    assign aw_hs = aw_pend & i_aw_ready;
    assign w_hs  = w_pend & i_w_ready;
    assign b_hs  = i_b_valid & o_b_ready;

    // Pending flags double as the valids.
    assign o_aw_valid = aw_pend;
    assign o_w_valid  = w_pend;
    assign o_b_ready  = (state == WR_RESP);
    assign o_busy     = (state != WR_IDLE);

    // Request payload, captured on an accepted start.
    always_ff @(posedge clk) begin
        if (state == WR_IDLE && i_start) begin
            o_aw.addr <= i_addr;
            o_w.data  <= i_data;
            o_w.strb  <= i_strb;
        end
    end

    // ----------------------------------------------------------------------
    // Write FSM.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= WR_IDLE;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
            o_result <= '0;
        end else begin
            o_result.done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (i_start) begin
                        state   <= WR_SEND;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
                WR_SEND: begin
                    // Address and data may be taken in different cycles.
                    if (aw_hs) aw_pend <= 1'b0;
                    if (w_hs) w_pend <= 1'b0;
                    if ((aw_hs || !aw_pend) && (w_hs || !w_pend)) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_hs) begin
                        state          <= WR_IDLE;
                        o_result.done  <= 1'b1;
                        o_result.fault <= (i_b.resp != RESP_OKAY);
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // AW valid stays up until the target takes the address.
    a_aw_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_aw_valid && !i_aw_ready |=> o_aw_valid)
        else $error("AW valid dropped before handshake");

endmodule

/* logic/axil_master_read.sv */
// AXI4-Lite read engine; one start strobe issues a single read and returns data and status.
`timescale 1ns/1ps

module axil_master_read
    import axil_pkg::*;
(
    // Clock and reset.
    input  logic              clk,
    input  logic              i_arst_n,

    // User request.
    input  logic              i_start,
    input  logic [ADDR_W-1:0] i_addr,

    // Read address channel.
    input  logic              i_ar_ready,
    output logic              o_ar_valid,
    output axil_ar_t          o_ar,

    // Read data channel.
    input  logic              i_r_valid,
    input  axil_r_t           i_r,
    output logic              o_r_ready,

    // Status.
    output logic              o_busy,
    output eng_result_t       o_result
);
    rd_state_e state;
    logic      ar_hs;
    logic      r_hs;

    assign o_ar_valid = (state == RD_ADDR);
    assign o_r_ready  = (state == RD_DATA);
    assign o_busy     = (state != RD_IDLE);
    assign ar_hs      = o_ar_valid & i_ar_ready;
    assign r_hs       = i_r_valid & o_r_ready;

    // Address captured on an accepted start.
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && i_start) o_ar.addr <= i_addr;
    end

    // ----------------------------------------------------------------------
    // Read FSM.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= RD_IDLE;
            o_result <= '0;
        end else begin
            o_result.done <= 1'b0;
            case (state)
                RD_IDLE: if (i_start) state <= RD_ADDR;
                RD_ADDR: if (ar_hs) state <= RD_DATA;
                RD_DATA: begin
                    if (r_hs) begin
                        state          <= RD_IDLE;
                        o_result.done  <= 1'b1;
                        o_result.fault <= (i_r.resp != RESP_OKAY);
                        o_result.data  <= i_r.data;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Address must not move while the target holds it off.
    a_ar_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_ar_valid && !i_ar_ready |=> $stable(o_ar))
        else $error("AR payload changed while waiting, addr %h", o_ar.addr);

endmodule

/* logic/axil_master.sv */
// AXI4-Lite master; runs the write and read engines side by side and merges their status.
`timescale 1ns/1ps

module axil_master
    import axil_pkg::*;
(
    // Clock and reset.
    input  logic              clk,
    input  logic              i_arst_n,

    // User side.
    input  logic              i_start_write,
    input  logic              i_start_read,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [STRB_W-1:0] i_strb,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_write_fault,
    output logic              o_read_fault,
    output logic              o_done,
    output logic              o_wr_busy,
    output logic              o_rd_busy,

    // Bus side.
    output logic              o_aw_valid,
    input  logic              i_aw_ready,
    output axil_aw_t          o_aw,
    output logic              o_w_valid,
    input  logic              i_w_ready,
    output axil_w_t           o_w,
    input  logic              i_b_valid,
    output logic              o_b_ready,
    input  axil_b_t           i_b,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    output axil_ar_t          o_ar,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    input  axil_r_t           i_r
);
    eng_result_t wr_result;
    eng_result_t rd_result;
    logic        start_wr;
    logic        start_rd;
    logic        rd_pend;
    logic        rd_take;

    // Starts to a busy engine are dropped.
    assign start_wr = i_start_write & ~o_wr_busy;
    assign start_rd = i_start_read & ~o_rd_busy;

    // Write wins a tie; the read is taken one cycle later.
    assign rd_take = (rd_result.done & ~wr_result.done) | rd_pend;

    axil_master_write write_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (start_wr),
        .i_addr     (i_addr),
        .i_data     (i_wdata),
        .i_strb     (i_strb),
        .i_aw_ready (i_aw_ready),
        .o_aw_valid (o_aw_valid),
        .o_aw       (o_aw),
        .i_w_ready  (i_w_ready),
        .o_w_valid  (o_w_valid),
        .o_w        (o_w),
        .i_b_valid  (i_b_valid),
        .i_b        (i_b),
        .o_b_ready  (o_b_ready),
        .o_busy     (o_wr_busy),
        .o_result   (wr_result)
    );

    axil_master_read read_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (start_rd),
        .i_addr     (i_addr),
        .i_ar_ready (i_ar_ready),
        .o_ar_valid (o_ar_valid),
        .o_ar       (o_ar),
        .i_r_valid  (i_r_valid),
        .i_r        (i_r),
        .o_r_ready  (o_r_ready),
        .o_busy     (o_rd_busy),
        .o_result   (rd_result)
    );

    // ----------------------------------------------------------------------
    // Status registers.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_done        <= 1'b0;
            o_write_fault <= 1'b0;
            o_read_fault  <= 1'b0;
            o_rdata       <= '0;
            rd_pend       <= 1'b0;
        end else begin
            o_done  <= wr_result.done | rd_result.done | rd_pend;
            rd_pend <= wr_result.done & rd_result.done;

            // A new start clears old status; a completion in the same cycle wins.
            if (start_wr) o_write_fault <= 1'b0;
            if (wr_result.done) o_write_fault <= wr_result.fault;

            if (start_rd) begin
                o_read_fault <= 1'b0;
                o_rdata      <= '0;
            end
            // Engine holds fault and data, so a deferred read still sees them.
            if (rd_take) begin
                o_read_fault <= rd_result.fault;
                o_rdata      <= rd_result.data;
            end
        end
    end

endmodule

/* logic/axil_mem_slave.sv */
// AXI4-Lite memory target with byte strobes, DECERR range check and a stall input for back-pressure.
`timescale 1ns/1ps

module axil_mem_slave
    import axil_pkg::*;
(
    // Clock, reset and stall.
    input  logic     clk,
    input  logic     i_arst_n,
    input  logic     i_stall,

    // Write address channel.
    input  logic     i_aw_valid,
    output logic     o_aw_ready,
    input  axil_aw_t i_aw,

    // Write data channel.
    input  logic     i_w_valid,
    output logic     o_w_ready,
    input  axil_w_t  i_w,

    // Write response channel.
    output logic     o_b_valid,
    input  logic     i_b_ready,
    output axil_b_t  o_b,

    // Read address channel.
    input  logic     i_ar_valid,
    output logic     o_ar_ready,
    input  axil_ar_t i_ar,

    // Read data channel.
    output logic     o_r_valid,
    input  logic     i_r_ready,
    output axil_r_t  o_r
);
    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic     aw_held;
    logic     w_held;
    axil_aw_t aw_q;
    axil_w_t  w_q;
    axil_aw_t wr_aw;
    axil_w_t  wr_w;
    logic     aw_hs;
    logic     w_hs;
    logic     ar_hs;
    logic     wr_commit;
    logic     wr_ok;
    logic     rd_ok;

    // True when the word index falls inside the array.
    function automatic logic in_range(input logic [ADDR_W-1:0] addr);
        return (addr[ADDR_W-1:MEM_IDX_W+2] == '0);
    endfunction

    // ----------------------------------------------------------------------
    // Handshakes.
    // ----------------------------------------------------------------------
    // One transaction per direction at a time.
    assign o_aw_ready = ~i_stall & ~aw_held & ~o_b_valid;
    assign o_w_ready  = ~i_stall & ~w_held & ~o_b_valid;
    assign o_ar_ready = ~i_stall & ~o_r_valid;

    assign aw_hs = i_aw_valid & o_aw_ready;
    assign w_hs  = i_w_valid & o_w_ready;
    assign ar_hs = i_ar_valid & o_ar_ready;

    // Commit once both halves are in, whether latched or arriving now.
    assign wr_commit = (aw_held | aw_hs) & (w_held | w_hs);
    assign wr_aw     = aw_held ? aw_q : i_aw;
    assign wr_w      = w_held ? w_q : i_w;
    assign wr_ok     = in_range(wr_aw.addr);
    assign rd_ok     = in_range(i_ar.addr);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            o_b_valid <= 1'b0;
            o_r_valid <= 1'b0;
        end else begin
            if (o_b_valid && i_b_ready) o_b_valid <= 1'b0;
            if (wr_commit) begin
                aw_held   <= 1'b0;
                w_held    <= 1'b0;
                o_b_valid <= 1'b1;
            end else begin
                if (aw_hs) aw_held <= 1'b1;
                if (w_hs) w_held <= 1'b1;
            end

            if (ar_hs) o_r_valid <= 1'b1;
            else if (o_r_valid && i_r_ready) o_r_valid <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Array access and response payloads.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (aw_hs) aw_q <= i_aw;
        if (w_hs) w_q <= i_w;

        if (wr_commit) begin
            o_b.resp <= wr_ok ? RESP_OKAY : RESP_DECERR;
            if (wr_ok) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (wr_w.strb[i]) begin
                        mem[wr_aw.addr[MEM_IDX_W+1:2]][8*i +: 8] <= wr_w.data[8*i +: 8];
                    end
                end
            end
        end

        if (ar_hs) begin
            o_r.data <= rd_ok ? mem[i_ar.addr[MEM_IDX_W+1:2]] : '0;
            o_r.resp <= rd_ok ? RESP_OKAY : RESP_DECERR;
        end
    end

    // Response stays offered until the master accepts it.
    a_b_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_b_valid && !i_b_ready |=> o_b_valid)
        else $error("B valid dropped before B ready");

endmodule

/* logic/axil_subsystem_top.sv */
// Subsystem top; wires the AXI4-Lite master to its memory target for standalone use.
`timescale 1ns/1ps

module axil_subsystem_top
    import axil_pkg::*;
(
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_start_write,
    input  logic              i_start_read,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [STRB_W-1:0] i_strb,
    input  logic              i_mem_stall,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_write_fault,
    output logic              o_read_fault,
    output logic              o_done,
    output logic              o_wr_busy,
    output logic              o_rd_busy
);
    // Bus between master and target.
    logic     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic     ar_valid, ar_ready, r_valid, r_ready;
    axil_aw_t aw;
    axil_w_t  w;
    axil_b_t  b;
    axil_ar_t ar;
    axil_r_t  r;

    axil_master master_i (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_start_write (i_start_write), .i_start_read (i_start_read),
        .i_addr (i_addr), .i_wdata (i_wdata), .i_strb (i_strb),
        .o_rdata (o_rdata), .o_write_fault (o_write_fault), .o_read_fault (o_read_fault),
        .o_done (o_done), .o_wr_busy (o_wr_busy), .o_rd_busy (o_rd_busy),
        .o_aw_valid (aw_valid), .i_aw_ready (aw_ready), .o_aw (aw),
        .o_w_valid (w_valid), .i_w_ready (w_ready), .o_w (w),
        .i_b_valid (b_valid), .o_b_ready (b_ready), .i_b (b),
        .o_ar_valid (ar_valid), .i_ar_ready (ar_ready), .o_ar (ar),
        .i_r_valid (r_valid), .o_r_ready (r_ready), .i_r (r)
    );

    axil_mem_slave mem_i (
        .clk (clk), .i_arst_n (i_arst_n), .i_stall (i_mem_stall),
        .i_aw_valid (aw_valid), .o_aw_ready (aw_ready), .i_aw (aw),
        .i_w_valid (w_valid), .o_w_ready (w_ready), .i_w (w),
        .o_b_valid (b_valid), .i_b_ready (b_ready), .o_b (b),
        .i_ar_valid (ar_valid), .o_ar_ready (ar_ready), .i_ar (ar),
        .o_r_valid (r_valid), .i_r_ready (r_ready), .o_r (r)
    );

endmodule

/* tb/tb_axil_subsystem.sv */
// Directed testbench for the AXI4-Lite subsystem; compile with build.f, top is tb_axil_subsystem.
`timescale 1ns/1ps

module tb_axil_subsystem
    import axil_pkg::*;
();
    localparam int TIMEOUT = 50;

    logic              clk;
    logic              arst_n;
    logic              start_write;
    logic              start_read;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_strb;
    logic              mem_stall;
    logic [DATA_W-1:0] rdata;
    logic              write_fault;
    logic              read_fault;
    logic              done;
    logic              wr_busy;
    logic              rd_busy;

    // Reference memory; only words that have been written are ever read back.
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    int                used_idx [8];
    int                mismatches;
    int                failures;

    axil_subsystem_top dut_i (
        .clk (clk), .i_arst_n (arst_n),
        .i_start_write (start_write), .i_start_read (start_read),
        .i_addr (req_addr), .i_wdata (req_wdata), .i_strb (req_strb),
        .i_mem_stall (mem_stall), .o_rdata (rdata),
        .o_write_fault (write_fault), .o_read_fault (read_fault),
        .o_done (done), .o_wr_busy (wr_busy), .o_rd_busy (rd_busy)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // Helpers.
    // ----------------------------------------------------------------------
    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("Mismatch %s: got %h expected %h", name, got, want);
        mismatches++;
    endtask

    task automatic flag_failure(input string msg);
        $display("Error: %s", msg);
        failures++;
    endtask

    // Byte lanes with a set strobe take the new data.
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // Waits for n done pulses, then watches a few cycles for stray ones.
    task automatic wait_pulses(input int n, input string what);
        int cycles;
        int pulses;
        cycles = 0;
        pulses = 0;
        while (pulses < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (done) pulses++;
        end
        if (pulses < n) flag_failure($sformatf("timeout waiting for o_done after %s", what));
        repeat (4) begin
            @(negedge clk);
            if (done) pulses++;
        end
        if (pulses != n) note_mismatch("o_done pulse count", pulses, n);
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
        logic want_fault;
        want_fault = (addr >= 32'd1024);
        if (!want_fault) ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, strb);
        req_addr    = addr;
        req_wdata   = data;
        req_strb    = strb;
        start_write = 1'b1;
        @(negedge clk);
        start_write = 1'b0;
        wait_pulses(1, "write");
        if (write_fault !== want_fault)
            note_mismatch("o_write_fault", 32'(write_fault), 32'(want_fault));
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] addr);
        logic              want_fault;
        logic [DATA_W-1:0] want_data;
        want_fault = (addr >= 32'd1024);
        want_data  = want_fault ? 32'h0 : ref_mem[addr[9:2]];
        req_addr   = addr;
        start_read = 1'b1;
        @(negedge clk);
        start_read = 0;
        wait_pulses(1, "read");
        if (read_fault !== want_fault)
            note_mismatch("o_read_fault", 32'(read_fault), 32'(want_fault));
        if (rdata !== want_data) note_mismatch("o_rdata", rdata, want_data);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests.
    // ----------------------------------------------------------------------
    task automatic check_reset_state();
        if (done !== 1'b0) note_mismatch("o_done", 32'(done), 32'h0);
        if (write_fault !== 1'b0) note_mismatch("o_write_fault", 32'(write_fault), 32'h0);
        if (read_fault !== 1'b0) note_mismatch("o_read_fault", 32'(read_fault), 32'h0);
        if (wr_busy !== 1'b0) note_mismatch("o_wr_busy", 32'(wr_busy), 32'h0);
        if (rd_busy !== 1'b0) note_mismatch("o_rd_busy", 32'(rd_busy), 32'h0);
        if (rdata !== 32'h0) note_mismatch("o_rdata", rdata, 32'h0);
    endtask

    task automatic write_then_read();
        int base;
        base = $urandom_range(0, 255);
        // Step of 29 keeps the eight word indices distinct.
        for (int i = 0; i < 8; i++) begin
            used_idx[i] = (base + 29 * i) % 256;
            do_write(used_idx[i] * 4, $urandom, 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            do_read(used_idx[i] * 4);
        end
    endtask

    task automatic exercise_strobes();
        logic [STRB_W-1:0] patterns [4];
        patterns = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        for (int i = 0; i < 4; i++) begin
            do_write(used_idx[i] * 4, $urandom, patterns[i]);
            do_read(used_idx[i] * 4);
        end
    endtask

    task automatic access_out_of_range();
        logic [ADDR_W-1:0] bad;
        // Upper bits out of range, low bits alias a written word.
        bad = ($urandom & 32'hFFFF_FC00) | 32'h0000_0400 | (used_idx[1] * 4);
        do_write(bad, $urandom, 4'hF);
        do_read(bad);
        // In-range read clears the read fault and shows the aliased word untouched.
        do_read(used_idx[1] * 4);
        if (write_fault !== 1'b1) note_mismatch("o_write_fault", 32'(write_fault), 32'h1);
    endtask

    task automatic stall_target();
        logic [ADDR_W-1:0] wr_addr;
        logic [ADDR_W-1:0] rd_addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] want_data;
        int                pulses;
        wr_addr   = used_idx[5] * 4;
        rd_addr   = used_idx[6] * 4;
        data      = $urandom;
        want_data = ref_mem[rd_addr[9:2]];
        ref_mem[wr_addr[9:2]] = data;
        mem_stall   = 1'b1;
        req_addr    = wr_addr;
        req_wdata   = data;
        req_strb    = 4'hF;
        start_write = 1'b1;
        @(negedge clk);
        start_write = 1'b0;
        req_addr    = rd_addr;
        start_read  = 1'b1;
        @(negedge clk);
        start_read = 1'b0;
        pulses = 0;
        repeat (12) begin
            @(negedge clk);
            if (done) pulses++;
        end
        if (pulses != 0) flag_failure("o_done pulsed while the target was stalled");
        // Both engines are still waiting on the target.
        if (wr_busy !== 1'b1) note_mismatch("o_wr_busy", 32'(wr_busy), 32'h1);
        if (rd_busy !== 1'b1) note_mismatch("o_rd_busy", 32'(rd_busy), 32'h1);
        mem_stall = 1'b0;
        wait_pulses(2, "stalled write and read");
        if (wr_busy !== 1'b0) note_mismatch("o_wr_busy", 32'(wr_busy), 32'h0);
        if (rd_busy !== 1'b0) note_mismatch("o_rd_busy", 32'(rd_busy), 32'h0);
        if (rdata !== want_data) note_mismatch("o_rdata", rdata, want_data);
        if (write_fault !== 1'b0) note_mismatch("o_write_fault", 32'(write_fault), 32'h0);
        if (read_fault !== 1'b0) note_mismatch("o_read_fault", 32'(read_fault), 32'h0);
        do_read(wr_addr);
    endtask

    // Both engines share the request address, so the read sees the word before the write.
    task automatic start_together();
        logic [ADDR_W-1:0] both_addr;
        logic [ADDR_W-1:0] busy_addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] prior;
        both_addr = used_idx[2] * 4;
        busy_addr = used_idx[3] * 4;
        data      = $urandom;
        prior     = ref_mem[both_addr[9:2]];
        ref_mem[both_addr[9:2]] = data;
        req_addr    = both_addr;
        req_wdata   = data;
        req_strb    = 4'hF;
        start_write = 1'b1;
        start_read  = 1'b1;
        @(negedge clk);
        start_read = 1'b0;
        // Write engine is busy now, so this second write is dropped.
        req_addr  = busy_addr;
        req_wdata = ~data;
        @(negedge clk);
        start_write = 1'b0;
        wait_pulses(2, "simultaneous write and read");
        if (rdata !== prior) note_mismatch("o_rdata", rdata, prior);
        if (write_fault !== 1'b0) note_mismatch("o_write_fault", 32'(write_fault), 32'h0);
        if (read_fault !== 1'b0) note_mismatch("o_read_fault", 32'(read_fault), 32'h0);
        do_read(both_addr);
        do_read(busy_addr);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence.
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h41d9));
        mismatches  = 0;
        failures    = 0;
        clk         = 1'b0;
        arst_n      = 1'b0;
        start_write = 1'b0;
        start_read  = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_strb    = '0;
        mem_stall   = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_reset_state();
        write_then_read();
        exercise_strobes();
        access_out_of_range();
        stall_target();
        start_together();
        $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
logic/axil_pkg.sv
logic/axil_master_write.sv
logic/axil_master_read.sv
logic/axil_master.sv
logic/axil_mem_slave.sv
logic/axil_subsystem_top.sv
tb/tb_axil_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axil_subsystem
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
